// ==== Bender.yml ====
package:
  name: proc

sources:
  - verilog/cpu_pkg.sv
  - verilog/pipe_pkg.sv
  - verilog/hazard_ctrl.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/mem_stage.sv
  - verilog/proc.sv
  - target: test
    files:
      - test/proc_asserts.sv
      - test/proc_tb.sv

// ==== flist.f ====
verilog/cpu_pkg.sv
verilog/pipe_pkg.sv
verilog/hazard_ctrl.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/proc.sv
test/proc_asserts.sv
test/proc_tb.sv

// ==== test/proc_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module proc_asserts (
   input wire logic           clk,
   input wire logic           rst_n,
   input wire cpu_pkg::word_t imem_addr,
   input wire pipe_pkg::wb_t  wb,
   input wire logic           halted,
   input wire logic           stall,
   input wire logic           drain
);

   int unsigned fail_count = 0;

   // Only reset clears halted
   halted_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
      else begin fail_count++; $error("halted fell without reset"); end

   no_wb_after_halt: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !wb.valid)
      else begin fail_count++; $error("writeback seen while halted"); end

   // PC never jumps, branches are gone
   pc_step: assert property (@(posedge clk) disable iff (!rst_n)
      imem_addr == $past(imem_addr) || imem_addr == $past(imem_addr) + 16'd1)
      else begin fail_count++; $error("imem_addr moved by more than one word"); end

   quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !stall && !drain)
      else begin fail_count++; $error("stall or drain high right after reset"); end

endmodule

bind proc proc_asserts asserts_inst (
   .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .wb(wb),
   .halted(halted), .stall(stall), .drain(drain)
);

`default_nettype wire

// ==== test/proc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module proc_tb;

   import cpu_pkg::*;
   import pipe_pkg::*;

   localparam int DMEM_DEPTH    = 64;
   localparam int ROM_DEPTH     = 64;
   localparam int HALT_TIMEOUT  = 200;
   localparam int NUM_BEHAVIORS = 6;

   // One program line with its expected writeback
   typedef struct packed {
      logic [2:0] behavior;
      word_t      instr;
      logic       has_wb;
      reg_idx_t   dest;
      word_t      data;
   } row_t;

   typedef struct packed {
      logic [2:0] behavior;
      logic [7:0] row;
      wb_t        wb;
   } expect_t;

   logic    clk;
   logic    rst_n;
   word_t   imem_addr;
   word_t   imem_data;
   wb_t     wb;
   logic    halted;

   row_t    table_rows [$];
   expect_t expected [$];
   word_t   rom [ROM_DEPTH];
   word_t   model_regs [NUM_REGS];
   int      prog_len = 0;
   int      halt_row = 0;
   int      checks = 0;
   int      errors = 0;
   int      beh_left [1:NUM_BEHAVIORS];
   int      beh_errs [1:NUM_BEHAVIORS];
   string   beh_name [1:NUM_BEHAVIORS];
   integer  seed = 32'h1b0c_9e95;

   proc #(.DMEM_DEPTH(DMEM_DEPTH)) proc_inst (
      .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
      .wb(wb), .halted(halted)
   );

   // Instruction ROM, HALT beyond the last program word
   assign imem_data = (imem_addr < prog_len) ? rom[imem_addr] : {OP_HALT, 11'd0};

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic word_t r_instr(opcode_t op, reg_idx_t rs, reg_idx_t rt,
                                     reg_idx_t rd);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   function automatic word_t i_instr(opcode_t op, reg_idx_t rs, reg_idx_t rd,
                                     logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic word_t lbi_instr(reg_idx_t rd, logic [7:0] imm);
      return {OP_LBI, rd, imm};
   endfunction

   // Keeps the register model in step with each row
   task automatic add_row(input int beh, input word_t instr, input logic has_wb,
                          input reg_idx_t dest, input word_t data);
      table_rows.push_back('{behavior: 3'(beh), instr: instr, has_wb: has_wb,
                             dest: dest, data: data});
      if (has_wb) begin
         model_regs[dest] = data;
      end
   endtask

   task automatic check_wb(input string name, input wb_t exp, input wb_t act,
                           output bit ok);
      checks++;
      ok = (act === exp);
      if (!ok) begin
         errors++;
         $display("error: %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act,
                             output bit ok);
      checks++;
      ok = (act === exp);
      if (!ok) begin
         errors++;
         $display("error: %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic report_behavior(input int b);
      $display("%s behavior %0d (%s): %0d errors", (beh_errs[b] == 0) ? "pass" : "fail",
               b, beh_name[b], beh_errs[b]);
   endtask

   // wb only changes on the rising edge, so look half a cycle later
   always @(negedge clk) begin
      expect_t e;
      bit      ok;
      if (rst_n === 1'b1 && wb.valid === 1'b1) begin
         if (expected.size() == 0) begin
            errors++;
            beh_errs[5]++;
            $display("unexpected writeback of %h to r%0d after the last expected one",
                     wb.data, wb.dest);
         end else begin
            e = expected.pop_front();
            check_wb($sformatf("wb (row %0d)", e.row), e.wb, wb, ok);
            if (!ok) begin
               beh_errs[e.behavior]++;
            end
            beh_left[e.behavior]--;
            if (beh_left[e.behavior] == 0) begin
               report_behavior(e.behavior);
            end
         end
      end
   end

   initial begin
      bit         ok;
      int         cycles;
      logic [4:0] imm;
      reg_idx_t   src;
      reg_idx_t   dst;
      rst_n = 1'b0;
      beh_name[1] = "LBI and ADDI";
      beh_name[2] = "dependent ALU chain";
      beh_name[3] = "store then load";
      beh_name[4] = "load-use stall";
      beh_name[5] = "halt drain";
      beh_name[6] = "random ADDI chain";

      add_row(1, lbi_instr(3'd1, 8'h25), 1, 3'd1, 16'h0025);
      add_row(1, {OP_NOP, 11'd0}, 0, 3'd0, 16'h0);
      add_row(1, {OP_NOP, 11'd0}, 0, 3'd0, 16'h0);
      add_row(1, lbi_instr(3'd2, 8'hfd), 1, 3'd2, 16'hfffd);
      add_row(1, {OP_NOP, 11'd0}, 0, 3'd0, 16'h0);
      add_row(1, {OP_NOP, 11'd0}, 0, 3'd0, 16'h0);
      add_row(1, i_instr(OP_ADDI, 3'd1, 3'd3, 5'd7), 1, 3'd3, 16'h002c);
      add_row(1, {OP_NOP, 11'd0}, 0, 3'd0, 16'h0);
      add_row(1, i_instr(OP_ADDI, 3'd2, 3'd4, 5'h10), 1, 3'd4, 16'hffed);
      // Back to back, operands one and two slots behind
      add_row(2, r_instr(OP_ADD, 3'd1, 3'd3, 3'd5), 1, 3'd5, 16'h0051);
      add_row(2, r_instr(OP_SUB, 3'd5, 3'd1, 3'd6), 1, 3'd6, 16'h002c);
      add_row(2, r_instr(OP_XOR, 3'd5, 3'd6, 3'd7), 1, 3'd7, 16'h007d);
      add_row(2, r_instr(OP_ADD, 3'd7, 3'd5, 3'd5), 1, 3'd5, 16'h00ce);
      add_row(2, r_instr(OP_SUB, 3'd6, 3'd7, 3'd6), 1, 3'd6, 16'hffaf);
      add_row(2, r_instr(OP_XOR, 3'd6, 3'd5, 3'd1), 1, 3'd1, 16'hff61);
      // 0x3c+6 and 1+1 both land on word 2, 1-2 and 0x3c+3 on word 63
      add_row(3, lbi_instr(3'd2, 8'h3c), 1, 3'd2, 16'h003c);
      add_row(3, i_instr(OP_ST, 3'd2, 3'd5, 5'd6), 0, 3'd0, 16'h0);
      add_row(3, lbi_instr(3'd3, 8'h01), 1, 3'd3, 16'h0001);
      add_row(3, i_instr(OP_LD, 3'd3, 3'd4, 5'd1), 1, 3'd4, 16'h00ce);
      add_row(3, i_instr(OP_ST, 3'd3, 3'd6, 5'h1e), 0, 3'd0, 16'h0);
      add_row(3, {OP_NOP, 11'd0}, 0, 3'd0, 16'h0);
      add_row(3, i_instr(OP_LD, 3'd2, 3'd7, 5'd3), 1, 3'd7, 16'hffaf);
      add_row(4, i_instr(OP_LD, 3'd2, 3'd1, 5'd6), 1, 3'd1, 16'h00ce);
      add_row(4, r_instr(OP_ADD, 3'd1, 3'd7, 3'd5), 1, 3'd5, 16'h007d);
      add_row(4, i_instr(OP_LD, 3'd2, 3'd3, 5'd3), 1, 3'd3, 16'hffaf);
      add_row(4, r_instr(OP_SUB, 3'd5, 3'd3, 3'd4), 1, 3'd4, 16'h00ce);
      src = 3'd4;
      for (int i = 0; i < 8; i++) begin
         imm = 5'($random(seed));
         dst = (i % 2 == 0) ? 3'd6 : 3'd7;
         add_row(6, i_instr(OP_ADDI, src, dst, imm), 1, dst,
                 model_regs[src] + {{11{imm[4]}}, imm});
         src = dst;
      end
      // Nothing behind HALT may write back
      halt_row = table_rows.size();
      add_row(5, {OP_HALT, 11'd0}, 0, 3'd0, 16'h0);
      add_row(5, lbi_instr(3'd1, 8'h77), 0, 3'd0, 16'h0);
      add_row(5, i_instr(OP_ADDI, 3'd1, 3'd2, 5'd1), 0, 3'd0, 16'h0);

      foreach (table_rows[i]) begin
         rom[i] = table_rows[i].instr;
         if (table_rows[i].has_wb) begin
            expected.push_back('{behavior: table_rows[i].behavior, row: 8'(i),
                                 wb: '{valid: 1'b1, dest: table_rows[i].dest,
                                       data: table_rows[i].data}});
            beh_left[table_rows[i].behavior]++;
         end
      end
      prog_len = table_rows.size();

      repeat (3) @(negedge clk);
      rst_n = 1'b1;

      cycles = 0;
      while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (halted !== 1'b1) begin
         errors++;
         beh_errs[5]++;
         $display("halted never rose within %0d cycles", HALT_TIMEOUT);
      end
      repeat (6) @(negedge clk);
      // PC stopped one word past HALT
      check_word("imem_addr", word_t'(halt_row + 1), imem_addr, ok);
      if (!ok) begin
         beh_errs[5]++;
      end
      if (expected.size() != 0) begin
         errors++;
         beh_errs[5]++;
         $display("%0d expected writebacks never appeared", expected.size());
      end
      for (int b = 1; b <= NUM_BEHAVIORS; b++) begin
         if (b != 5 && beh_left[b] > 0) begin
            beh_errs[b] += beh_left[b];
            report_behavior(b);
         end
      end
      report_behavior(5);
      if (proc_inst.asserts_inst.fail_count != 0) begin
         errors += proc_inst.asserts_inst.fail_count;
         $display("%0d assertion failures in proc_asserts",
                  proc_inst.asserts_inst.fail_count);
      end

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   localparam int NUM_REGS = 8;

   // Top five bits of every instruction
   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_ADDI = 5'b01000,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_LBI  = 5'b11000,
      OP_SUB  = 5'b11001,
      OP_ADD  = 5'b11011,
      OP_XOR  = 5'b11100
   } opcode_t;

   typedef struct packed {
      opcode_t     opcode;
      logic [10:0] body;
   } instr_t;

   // R-type body
   typedef struct packed {
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [1:0] pad;
   } r_body_t;

   // I-type body
   // ST keeps the register it stores in the rd field
   typedef struct packed {
      reg_idx_t   rs;
      reg_idx_t   rd;
      logic [4:0] imm;
   } i_body_t;

   typedef struct packed {
      reg_idx_t   rd;
      logic [7:0] imm;
   } lbi_body_t;

   localparam instr_t NOP_INSTR = '{opcode: OP_NOP, body: '0};

   // Which source fields an opcode actually reads
   function automatic logic uses_rs(opcode_t op);
      return op inside {OP_ADD, OP_SUB, OP_XOR, OP_ADDI, OP_LD, OP_ST};
   endfunction

   function automatic logic uses_rt(opcode_t op);
      return op inside {OP_ADD, OP_SUB, OP_XOR, OP_ST};
   endfunction

endpackage

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              stall,
   input  wire pipe_pkg::if_id_t  if_id,
   input  wire pipe_pkg::wb_t     wb,
   output pipe_pkg::id_ex_t       id_ex
);

   import cpu_pkg::*;
   import pipe_pkg::*;

   word_t     rf [NUM_REGS];
   opcode_t   op;
   r_body_t   r_f;
   i_body_t   i_f;
   lbi_body_t l_f;
   word_t     rs_val;
   word_t     rt_val;
   id_ex_t    dec;

   assign op  = if_id.instr.opcode;
   assign r_f = r_body_t'(if_id.instr.body);
   assign i_f = i_body_t'(if_id.instr.body);
   assign l_f = lbi_body_t'(if_id.instr.body);

   always_ff @(posedge clk) begin
      if (wb.valid) begin
         rf[wb.dest] <= wb.data;
      end
   end

   // Same-cycle writeback goes straight through
   assign rs_val = (wb.valid && wb.dest == r_f.rs) ? wb.data : rf[r_f.rs];
   assign rt_val = (wb.valid && wb.dest == r_f.rt) ? wb.data : rf[r_f.rt];

   always_comb begin
      dec        = ID_EX_NOP;
      dec.opcode = op;
      dec.rs     = r_f.rs;
      dec.rt     = r_f.rt;
      dec.rs_val = rs_val;
      dec.rt_val = rt_val;
      dec.imm    = {{11{i_f.imm[4]}}, i_f.imm};
      case (op)
         OP_ADD, OP_SUB, OP_XOR: begin
            dec.dest      = r_f.rd;
            dec.reg_write = 1'b1;
         end
         OP_ADDI: begin
            dec.dest      = i_f.rd;
            dec.reg_write = 1'b1;
         end
         OP_LD: begin
            dec.dest      = i_f.rd;
            dec.reg_write = 1'b1;
            dec.mem_read  = 1'b1;
         end
         // Store data register sits in the rt position
         OP_ST: begin
            dec.mem_write = 1'b1;
         end
         OP_LBI: begin
            dec.dest      = l_f.rd;
            dec.imm       = {{8{l_f.imm[7]}}, l_f.imm};
            dec.reg_write = 1'b1;
         end
         OP_HALT: begin
            dec.halt = 1'b1;
         end
         default: begin
            dec.opcode = OP_NOP;
         end
      endcase
   end

   // Bubble goes in while the load ahead finishes
   always_ff @(posedge clk) begin
      if (!rst_n || stall) begin
         id_ex <= ID_EX_NOP;
      end else begin
         id_ex <= dec;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire pipe_pkg::id_ex_t   id_ex,
   input  wire pipe_pkg::fwd_sel_t fwd_a,
   input  wire pipe_pkg::fwd_sel_t fwd_b,
   input  wire pipe_pkg::wb_t      wb,
   output pipe_pkg::ex_mem_t       ex_mem
);

   import cpu_pkg::*;
   import pipe_pkg::*;

   word_t op_a;
   word_t op_b;
   word_t alu_out;

   function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t ex_val,
                                     word_t wb_val);
      case (sel)
         FWD_EX_MEM: return ex_val;
         FWD_MEM_WB: return wb_val;
         default:    return reg_val;
      endcase
   endfunction

   assign op_a = fwd_mux(fwd_a, id_ex.rs_val, ex_mem.alu_result, wb.data);
   assign op_b = fwd_mux(fwd_b, id_ex.rt_val, ex_mem.alu_result, wb.data);

   always_comb begin
      case (id_ex.opcode)
         OP_ADD:  alu_out = op_a + op_b;
         // rs minus rt
         OP_SUB:  alu_out = op_a - op_b;
         OP_XOR:  alu_out = op_a ^ op_b;
         OP_ADDI, OP_LD, OP_ST: begin
            alu_out = op_a + id_ex.imm;
         end
         OP_LBI:  alu_out = id_ex.imm;
         default: alu_out = '0;
      endcase
   end

   // Store data rides along already forwarded
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_mem <= EX_MEM_NOP;
      end else begin
         ex_mem <= '{
            dest:       id_ex.dest,
            reg_write:  id_ex.reg_write,
            mem_read:   id_ex.mem_read,
            mem_write:  id_ex.mem_write,
            halt:       id_ex.halt,
            alu_result: alu_out,
            store_data: op_b
         };
      end
   end

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
   input  wire logic            clk,
   input  wire logic            rst_n,
   input  wire logic            stall,
   input  wire logic            drain,
   input  wire cpu_pkg::word_t  imem_data,
   output cpu_pkg::word_t       imem_addr,
   output pipe_pkg::if_id_t     if_id
);

   import cpu_pkg::*;
   import pipe_pkg::*;

   word_t pc;
   logic  halt_held;
   logic  hold_pc;

   assign imem_addr = pc;

   // The word fetched behind HALT must never enter IF/ID
   assign halt_held = (if_id.instr.opcode == OP_HALT);
   assign hold_pc   = stall || drain || halt_held;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (!hold_pc) begin
         pc <= pc + 16'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         if_id <= IF_ID_NOP;
      end else if (drain || halt_held) begin
         if_id <= IF_ID_NOP;
      end else if (!stall) begin
         if_id <= '{instr: instr_t'(imem_data)};
      end
   end

endmodule

`default_nettype wire

// ==== verilog/hazard_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire pipe_pkg::if_id_t   if_id,
   input  wire pipe_pkg::id_ex_t   id_ex,
   input  wire pipe_pkg::ex_mem_t  ex_mem,
   input  wire pipe_pkg::wb_t      wb,
   output logic                    stall,
   output logic                    drain,
   output pipe_pkg::fwd_sel_t      fwd_a,
   output pipe_pkg::fwd_sel_t      fwd_b
);

   import cpu_pkg::*;
   import pipe_pkg::*;

   opcode_t dec_op;
   r_body_t src;
   logic    rs_hit;
   logic    rt_hit;

   // Youngest writer wins
   function automatic fwd_sel_t fwd_pick(reg_idx_t r, ex_mem_t em, wb_t w);
      if (em.reg_write && em.dest == r) begin
         return FWD_EX_MEM;
      end
      if (w.valid && w.dest == r) begin
         return FWD_MEM_WB;
      end
      return FWD_NONE;
   endfunction

   assign dec_op = if_id.instr.opcode;
   assign src    = r_body_t'(if_id.instr.body);

   // Load data only exists after MEM, so a direct consumer waits one slot
   assign rs_hit = uses_rs(dec_op) && (src.rs == id_ex.dest);
   assign rt_hit = uses_rt(dec_op) && (src.rt == id_ex.dest);
   assign stall  = id_ex.mem_read && (rs_hit || rt_hit);

   assign fwd_a = fwd_pick(id_ex.rs, ex_mem, wb);
   assign fwd_b = fwd_pick(id_ex.rt, ex_mem, wb);

   // Sticky once HALT has left IF/ID
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         drain <= 1'b0;
      end else if (dec_op == OP_HALT && !stall) begin
         drain <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_stage #(
   parameter int DMEM_DEPTH = 64
) (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire pipe_pkg::ex_mem_t  ex_mem,
   output pipe_pkg::wb_t           wb,
   output logic                    halted
);

   import cpu_pkg::*;
   import pipe_pkg::*;

   localparam int AW = $clog2(DMEM_DEPTH);

   word_t         dmem [DMEM_DEPTH];
   logic [AW-1:0] addr;
   word_t         load_data;

   // High address bits dropped so addresses wrap
   assign addr      = ex_mem.alu_result[AW-1:0];
   assign load_data = dmem[addr];

   always_ff @(posedge clk) begin
      if (ex_mem.mem_write) begin
         dmem[addr] <= ex_mem.store_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb     <= WB_NONE;
         halted <= 1'b0;
      end else begin
         wb <= '{
            valid: ex_mem.reg_write,
            dest:  ex_mem.dest,
            data:  ex_mem.mem_read ? load_data : ex_mem.alu_result
         };
         // Stays up until reset
         if (ex_mem.halt) begin
            halted <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

   import cpu_pkg::*;

   // Operand source picked in execute
   typedef enum logic [1:0] {
      FWD_NONE,
      FWD_EX_MEM,
      FWD_MEM_WB
   } fwd_sel_t;

   typedef struct packed {
      instr_t instr;
   } if_id_t;

   typedef struct packed {
      opcode_t  opcode;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t dest;
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     halt;
      word_t    rs_val;
      word_t    rt_val;
      word_t    imm;
   } id_ex_t;

   typedef struct packed {
      reg_idx_t dest;
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     halt;
      word_t    alu_result;
      word_t    store_data;
   } ex_mem_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t dest;
      word_t    data;
   } wb_t;

   // Empty slots
   localparam if_id_t  IF_ID_NOP  = '{instr: NOP_INSTR};
   localparam id_ex_t  ID_EX_NOP  = '{opcode: OP_NOP, default: '0};
   localparam ex_mem_t EX_MEM_NOP = '0;
   localparam wb_t     WB_NONE    = '0;

endpackage

`default_nettype wire

// ==== verilog/proc.sv ====
`timescale 1ns/1ns
`default_nettype none

module proc #(
   parameter int DMEM_DEPTH = 64
) (
   input  wire logic            clk,
   input  wire logic            rst_n,
   output cpu_pkg::word_t       imem_addr,
   input  wire cpu_pkg::word_t  imem_data,
   output pipe_pkg::wb_t        wb,
   output logic                 halted
);

   import pipe_pkg::*;

   logic     stall;
   logic     drain;
   fwd_sel_t fwd_a;
   fwd_sel_t fwd_b;
   if_id_t   if_id;
   id_ex_t   id_ex;
   ex_mem_t  ex_mem;

   hazard_ctrl hazard_inst (
      .clk(clk), .rst_n(rst_n),
      .if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .wb(wb),
      .stall(stall), .drain(drain), .fwd_a(fwd_a), .fwd_b(fwd_b)
   );

   fetch_stage fetch_inst (
      .clk(clk), .rst_n(rst_n), .stall(stall), .drain(drain),
      .imem_data(imem_data), .imem_addr(imem_addr), .if_id(if_id)
   );

   decode_stage decode_inst (
      .clk(clk), .rst_n(rst_n), .stall(stall),
      .if_id(if_id), .wb(wb), .id_ex(id_ex)
   );

   execute_stage execute_inst (
      .clk(clk), .rst_n(rst_n), .id_ex(id_ex),
      .fwd_a(fwd_a), .fwd_b(fwd_b), .wb(wb), .ex_mem(ex_mem)
   );

   // Data memory size set here
   mem_stage #(
      .DMEM_DEPTH(DMEM_DEPTH)
   ) mem_inst (
      .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem),
      .wb(wb), .halted(halted)
   );

endmodule

`default_nettype wire
